/* all.f */
hdl/fe_cfg_pkg.sv
hdl/fe_types_pkg.sv
hdl/flush_unit.sv
hdl/fetch_seq.sv
hdl/inst_fifo.sv
hdl/decode_stage.sv
hdl/fe_top.sv
test/fe_tb.sv

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        empty,
    input  fetch_pkt_t  head,
    output logic        pop,
    input  logic        flush,
    input  logic        issue_ready,
    output issue_t      issue,
    output flush_req_t  id_flush
);

    logic            stg_valid;
    logic [xlen-1:0] stg_pc;
    logic [xlen-1:0] stg_inst;
    logic            stg_jump;
    logic [xlen-1:0] jal_imm;

    // take a new word when the register is free or drains this cycle
    assign pop = ~empty & ~flush & (~stg_valid | issue_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stg_valid <= 1'b0;
        end else if (flush) begin
            stg_valid <= 1'b0;
        end else if (pop) begin
            stg_valid <= 1'b1;
        end else if (issue_ready) begin
            stg_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            stg_pc   <= head.pc;
            stg_inst <= head.inst;
            stg_jump <= (head.inst[6:0] == opc_jal);
        end
    end

    assign issue.valid   = stg_valid;
    assign issue.pc      = stg_pc;
    assign issue.inst    = stg_inst;
    assign issue.is_jump = stg_jump;

    // J-type immediate, sign extended
    assign jal_imm = {{(xlen - 21){stg_inst[31]}}, stg_inst[31], stg_inst[19:12],
                      stg_inst[20], stg_inst[30:21], 1'b0};

    // redirect only once the jump actually leaves the stage
    assign id_flush.valid  = stg_valid & stg_jump & issue_ready;
    assign id_flush.target = stg_pc + jal_imm;

    // back end sees a steady instruction while it stalls
    assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid && !issue_ready && !flush |=> $stable(issue))
        else $error("issue changed while stalled");

endmodule

`default_nettype wire

/* hdl/fe_cfg_pkg.sv */
`default_nettype none

package fe_cfg_pkg;

    // datapath width, pc and instruction word
    localparam int xlen = 32;

    // instruction queue sizing
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

    // RV32 direct jump opcode
    localparam logic [6:0] opc_jal = 7'b1101111;

    // sequential fetch increment
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // boot address
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

/* hdl/fe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_top
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_rdata,
    input  be_flush_t        be_flush,
    input  logic             issue_ready,
    output issue_t           issue,
    output be_flush_vec_t    be_flush_vec,
    output fe_flush_vec_t    fe_flush_vec
);

    logic            push;
    fetch_pkt_t      push_pkt;
    logic            pop;
    fetch_pkt_t      head;
    logic            full;
    logic            empty;
    flush_req_t      id_flush;
    logic [xlen-1:0] redirect_pc;

    flush_unit u_flush (
        .be_flush     (be_flush),
        .id_flush     (id_flush),
        .be_flush_vec (be_flush_vec),
        .fe_flush_vec (fe_flush_vec),
        .redirect_pc  (redirect_pc)
    );

    fetch_seq u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .full        (full),
        .redirect    (fe_flush_vec.if0),
        .redirect_pc (redirect_pc),
        .push        (push),
        .push_pkt    (push_pkt)
    );

    inst_fifo #(
        .payload_t (fetch_pkt_t)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (fe_flush_vec.fifo),
        .push      (push),
        .push_data (push_pkt),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .empty       (empty),
        .head        (head),
        .pop         (pop),
        .flush       (fe_flush_vec.fifo_id),
        .issue_ready (issue_ready),
        .issue       (issue),
        .id_flush    (id_flush)
    );

endmodule

`default_nettype wire

/* hdl/fe_types_pkg.sv */
`default_nettype none

package fe_types_pkg;

    import fe_cfg_pkg::*;

    // one fetched word and the address it came from
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_pkt_t;

    // a single flush request with its redirect target
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } flush_req_t;

    // back-end requesters, highest priority first
    // reg_st is the register read stage
    typedef struct packed {
        flush_req_t wb;
        flush_req_t ex2;
        flush_req_t ex1;
        flush_req_t priv;
        flush_req_t reg_st;
    } be_flush_t;

    typedef struct packed {
        logic ex2_wb;
        logic ex1_ex2;
        logic reg_ex1;
        logic id_reg;
        logic tlb;
        logic dcache;
    } be_flush_vec_t;

    typedef struct packed {
        logic if0;
        logic if0_if1;
        logic if1_fifo;
        logic fifo;
        logic fifo_id;
        logic icache;
        logic btb;
    } fe_flush_vec_t;

    // instruction handed to the back end
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            is_jump;
    } issue_t;

endpackage

`default_nettype wire

/* hdl/fetch_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_seq
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    output logic [xlen-1:0]  imem_addr,
    input  logic [xlen-1:0]  imem_rdata,
    input  logic             full,
    input  logic             redirect,
    input  logic [xlen-1:0]  redirect_pc,
    output logic             push,
    output fetch_pkt_t       push_pkt
);

    logic [xlen-1:0] pc;
    logic            fetch_on;

    // fetch starts on the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_on <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
        end
    end

    assign imem_addr = pc;

    // memory answers in the same cycle, so the word pairs with pc directly
    assign push          = fetch_on & ~full & ~redirect;
    assign push_pkt.pc   = pc;
    assign push_pkt.inst = imem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (push) begin
            pc <= pc + pc_step;
        end
    end

    // queue full must hold fetch
    assert property (@(posedge clk) disable iff (!arst_n) !(push && full))
        else $error("push while instruction queue full");

endmodule

`default_nettype wire

/* hdl/flush_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module flush_unit
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;
(
    input  be_flush_t        be_flush,
    input  flush_req_t       id_flush,
    output be_flush_vec_t    be_flush_vec,
    output fe_flush_vec_t    fe_flush_vec,
    output logic [xlen-1:0]  redirect_pc
);

    logic wb_v;
    logic ex2_v;
    logic ex1_v;
    logic priv_v;
    logic reg_v;
    logic id_v;
    logic any_v;

    assign wb_v   = be_flush.wb.valid;
    assign ex2_v  = be_flush.ex2.valid;
    assign ex1_v  = be_flush.ex1.valid;
    assign priv_v = be_flush.priv.valid;
    assign reg_v  = be_flush.reg_st.valid;
    assign id_v   = id_flush.valid;
    assign any_v  = wb_v | ex2_v | ex1_v | priv_v | reg_v | id_v;

    // each boundary is cleared by every stage behind it
    always_comb begin
        be_flush_vec.ex2_wb  = wb_v;
        be_flush_vec.ex1_ex2 = wb_v | ex2_v;
        be_flush_vec.reg_ex1 = wb_v | ex2_v | ex1_v | priv_v;
        be_flush_vec.id_reg  = be_flush_vec.reg_ex1 | reg_v;
        be_flush_vec.tlb     = wb_v | ex2_v | priv_v;
        be_flush_vec.dcache  = be_flush_vec.reg_ex1;

        fe_flush_vec.fifo_id  = be_flush_vec.id_reg | id_v;
        fe_flush_vec.fifo     = be_flush_vec.id_reg | id_v;
        // only the late redirects reach the if1 boundary
        fe_flush_vec.if1_fifo = wb_v | priv_v | ex1_v;
        fe_flush_vec.if0_if1  = any_v;
        fe_flush_vec.if0      = fe_flush_vec.if0_if1;
        fe_flush_vec.icache   = fe_flush_vec.if0_if1;
        fe_flush_vec.btb      = fe_flush_vec.if0_if1;
    end

    // oldest requester wins the redirect
    always_comb begin
        if (wb_v) begin
            redirect_pc = be_flush.wb.target;
        end else if (ex2_v) begin
            redirect_pc = be_flush.ex2.target;
        end else if (ex1_v) begin
            redirect_pc = be_flush.ex1.target;
        end else if (priv_v) begin
            redirect_pc = be_flush.priv.target;
        end else if (reg_v) begin
            redirect_pc = be_flush.reg_st.target;
        end else begin
            redirect_pc = id_flush.target;
        end
    end

    // a request from anywhere must restart fetch
    always_comb begin
        assert (!any_v || fe_flush_vec.if0)
            else $error("flush request without if0 redirect");
    end

endmodule

`default_nettype wire

/* hdl/inst_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_fifo
    import fe_cfg_pkg::*;
#(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     full,
    output logic     empty
);

    localparam logic [fifo_ptr_w:0] depth_c = (fifo_ptr_w + 1)'(fifo_depth);

    payload_t                mem [fifo_depth];
    logic [fifo_ptr_w-1:0]   wr_ptr;
    logic [fifo_ptr_w-1:0]   rd_ptr;
    logic [fifo_ptr_w:0]     count;
    logic                    do_push;
    logic                    do_pop;

    assign full  = (count == depth_c);
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // flush wins over both ends
    assign do_push = push & ~flush;
    assign do_pop  = pop & ~flush;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else $error("pop from empty queue");

    assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else $error("push into full queue");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -f all.f --top-module fe_tb -Mdir build -o fe_sim \
    > build/compile.log 2>&1 \
    && ./build/fe_sim > build/sim.log 2>&1 \
    || { cat build/compile.log build/sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat build/sim.log
grep -qx "all tests passed" build/sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/fe_stimulus.txt */
// words 00-3f: instruction memory, one word per pc/4, unlisted words are nops
// words 40+: 16 words per test
//   stall event_cycle source_mask(wb ex2 ex1 priv reg) win_target other_target
//   exp_be_vec exp_fe_vec n_pcs, then up to 8 expected issue pcs in order
@00
00000013 00000013 00000013 00000013 00000013 00000013 0280006f
@40
// reset and sequential fetch
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000006
00000000 00000004 00000008 0000000c 00000010 00000014 00000000 00000000
// direct jump at 18 to 40
00000000 00000009 00000000 00000000 00000000 00000000 0000006f 00000008
00000000 00000004 00000008 0000000c 00000010 00000014 00000018 00000040
// wb flush
00000000 00000006 00000010 00000080 00000000 0000003f 0000007f 00000006
00000000 00000004 00000008 00000080 00000084 00000088 00000000 00000000
// ex2 flush
00000000 00000006 00000008 00000090 00000000 0000001f 0000006f 00000006
00000000 00000004 00000008 00000090 00000094 00000098 00000000 00000000
// ex1 flush
00000000 00000006 00000004 000000a0 00000000 0000000d 0000007f 00000006
00000000 00000004 00000008 000000a0 000000a4 000000a8 00000000 00000000
// priv flush
00000000 00000006 00000002 000000b0 00000000 0000000f 0000007f 00000006
00000000 00000004 00000008 000000b0 000000b4 000000b8 00000000 00000000
// reg flush
00000000 00000006 00000001 000000c0 00000000 00000004 0000006f 00000006
00000000 00000004 00000008 000000c0 000000c4 000000c8 00000000 00000000
// wb and ex1 together, wb target wins
00000000 00000006 00000014 000000d0 000000e0 0000003f 0000007f 00000006
00000000 00000004 00000008 000000d0 000000d4 000000d8 00000000 00000000
// random stalls over the jump sequence
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000008
00000000 00000004 00000008 0000000c 00000010 00000014 00000018 00000040

/* test/fe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_tb
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;
();

    localparam int period_ns = 40;
    localparam int drive_ns  = 2;
    localparam int cycle_max = 60;
    localparam int test_base = 64;
    localparam int rec_words = 16;
    localparam logic [xlen-1:0] nop_c = 32'h0000_0013;

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_rdata;
    be_flush_t       be_flush;
    logic            issue_ready;
    issue_t          issue;
    be_flush_vec_t   be_flush_vec;
    fe_flush_vec_t   fe_flush_vec;

    // words 0..63 hold the memory image, test records follow
    logic [31:0] stim [0:255];
    logic [31:0] rnd;
    int          n_pass;
    int          n_fail;
    int          n_tests;
    logic        loaded;

    fe_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .be_flush     (be_flush),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .be_flush_vec (be_flush_vec),
        .fe_flush_vec (fe_flush_vec)
    );

    // instruction memory answers in the same cycle, nops above the image
    assign imem_rdata = (imem_addr[xlen-1:8] == '0) ? stim[imem_addr[7:2]] : nop_c;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word of the memory image at a byte address
    function automatic logic [xlen-1:0] image_word(input logic [xlen-1:0] a);
        if (a[xlen-1:8] == '0) begin
            return stim[a[7:2]];
        end
        return nop_c;
    endfunction

    function automatic flush_req_t make_req(input logic v, input logic win,
                                           input logic [xlen-1:0] t_win,
                                           input logic [xlen-1:0] t_other);
        flush_req_t r;
        r.valid  = v;
        r.target = win ? t_win : t_other;
        return r;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #(drive_ns);
        arst_n      = 1'b0;
        be_flush    = '0;
        issue_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
        end
        #(drive_ns);
        arst_n = 1'b1;
    endtask

    task automatic run_test(input int t);
        int              b;
        int              cyc;
        int              got;
        int              n_exp;
        int              top;
        int              stall_left;
        logic [4:0]      mask;
        logic            ok;
        logic            held;
        issue_t          last;
        logic [xlen-1:0] exp_pc;
        logic [xlen-1:0] exp_word;
        logic            exp_jump;

        b          = test_base + rec_words * t;
        n_exp      = int'(stim[b+7]);
        mask       = stim[b+2][4:0];
        top        = 0;
        ok         = 1'b1;
        got        = 0;
        cyc        = 0;
        stall_left = 0;
        held       = 1'b0;
        last       = '0;
        // highest set bit is the oldest requester
        for (int k = 0; k < 5; k++) begin
            if (mask[k]) begin
                top = k;
            end
        end
        apply_reset();
        while (got < n_exp && cyc < cycle_max) begin
            @(posedge clk);
            #(drive_ns);
            cyc++;
            if (cyc == int'(stim[b+1]) && mask != '0) begin
                be_flush.wb     = make_req(mask[4], top == 4, stim[b+3], stim[b+4]);
                be_flush.ex2    = make_req(mask[3], top == 3, stim[b+3], stim[b+4]);
                be_flush.ex1    = make_req(mask[2], top == 2, stim[b+3], stim[b+4]);
                be_flush.priv   = make_req(mask[1], top == 1, stim[b+3], stim[b+4]);
                be_flush.reg_st = make_req(mask[0], top == 0, stim[b+3], stim[b+4]);
            end else begin
                be_flush = '0;
            end
            if (stim[b] == 32'd0) begin
                issue_ready = 1'b1;
            end else if (stall_left > 0) begin
                issue_ready = 1'b0;
                stall_left--;
            end else begin
                rnd = next_rand(rnd);
                // start a stall window of one to four cycles now and then
                if (rnd[3:0] < 4'd5) begin
                    issue_ready = 1'b0;
                    stall_left  = int'(rnd[6:5]);
                end else begin
                    issue_ready = 1'b1;
                end
            end
            #1;
            if (cyc == 1) begin
                assert (!issue.valid) else begin
                    $display("ERROR at %0t ns: issue.valid = 1, expected 0", $time);
                    ok = 1'b0;
                end
                assert (be_flush_vec == '0 && fe_flush_vec == '0) else begin
                    $display("ERROR at %0t ns: flush vectors = %h %h, expected 00 00",
                             $time, be_flush_vec, fe_flush_vec);
                    ok = 1'b0;
                end
            end
            if (cyc == int'(stim[b+1])) begin
                assert (be_flush_vec == stim[b+5][5:0]) else begin
                    $display("ERROR at %0t ns: be_flush_vec = %h, expected %h",
                             $time, be_flush_vec, stim[b+5][5:0]);
                    ok = 1'b0;
                end
                assert (fe_flush_vec == stim[b+6][6:0]) else begin
                    $display("ERROR at %0t ns: fe_flush_vec = %h, expected %h",
                             $time, fe_flush_vec, stim[b+6][6:0]);
                    ok = 1'b0;
                end
            end
            // fetch restarts at the winning target one edge after the request
            if (mask != '0 && cyc == int'(stim[b+1]) + 1) begin
                assert (imem_addr == stim[b+3]) else begin
                    $display("ERROR at %0t ns: imem_addr = %h, expected %h",
                             $time, imem_addr, stim[b+3]);
                    ok = 1'b0;
                end
            end
            if (held) begin
                assert (issue == last) else begin
                    $display("ERROR at %0t ns: issue = %h, expected held %h",
                             $time, issue, last);
                    ok = 1'b0;
                end
            end
            // an instruction flushed at id_reg never reaches the back end
            if (issue.valid && issue_ready && !be_flush_vec.id_reg) begin
                exp_pc   = stim[b+8+got];
                exp_word = image_word(exp_pc);
                exp_jump = (exp_word[6:0] == opc_jal);
                assert (issue.pc == exp_pc) else begin
                    $display("ERROR at %0t ns: issue.pc = %h, expected %h",
                             $time, issue.pc, exp_pc);
                    ok = 1'b0;
                end
                assert (issue.inst == exp_word) else begin
                    $display("ERROR at %0t ns: issue.inst = %h, expected %h",
                             $time, issue.inst, exp_word);
                    ok = 1'b0;
                end
                assert (issue.is_jump == exp_jump) else begin
                    $display("ERROR at %0t ns: issue.is_jump = %b, expected %b",
                             $time, issue.is_jump, exp_jump);
                    ok = 1'b0;
                end
                got++;
            end
            held = issue.valid && !issue_ready && !fe_flush_vec.fifo_id;
            last = issue;
        end
        be_flush    = '0;
        issue_ready = 1'b1;
        assert (got == n_exp) else begin
            $display("test %0d: only %0d of %0d instructions issued within %0d cycles",
                     t, got, n_exp, cycle_max);
            ok = 1'b0;
        end
        if (ok) begin
            n_pass++;
            $display("test %0d passed", t);
        end else begin
            n_fail++;
            $display("test %0d failed", t);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        be_flush    = '0;
        issue_ready = 1'b1;
        rnd         = 32'hdafdba41;
        n_pass      = 0;
        n_fail      = 0;
        n_tests     = 0;
        loaded      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            stim[i] = (i < 64) ? nop_c : 32'd0;
        end
        $readmemh("test/fe_stimulus.txt", stim);
        // a record with no expected pcs ends the list
        while (n_tests < 12 && stim[test_base + rec_words * n_tests + 7] != 32'd0) begin
            n_tests++;
        end
        loaded = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("summary: %0d of %0d passed, %0d failed", n_pass, n_tests, n_fail);
        if (n_fail == 0 && n_tests > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // reset plus the cycle limit of every test, and some slack
    initial begin
        wait (loaded);
        #(n_tests * (cycle_max + 6) * period_ns + 10 * period_ns);
        $display("watchdog: simulation still running after its time budget");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
